// ==== src.f ====
+incdir+include
rtl/cpuPkg.sv
rtl/predecoder.sv
rtl/timingControl.sv
rtl/aluDecimal.sv
rtl/statusRegister.sv
rtl/busOutput.sv
rtl/cpuTop.sv
tb/tbCpuTop.sv

// ==== tb/tbCpuTop.sv ====
/* testbench for cpuTop: memory model, random program, instruction-level
   reference model, bus and status checks with random rdy stalls */
`timescale 1ns/1ps
`include "cpu_params.svh"

module tbCpuTop;

  localparam int NUM_INSTR  = 400;
  localparam int MAX_CYCLES = NUM_INSTR * 3 * 4 + 100;

  logic       fastClk = 1'b0;
  logic       rstN;
  logic       rdy;
  logic [7:0] dataIn;
  logic [15:0] addr;
  logic       rw;
  logic [7:0] dataOut;
  logic       sync;
  logic [7:0] status;

  logic [7:0] mem [0:65535];
  logic [7:0] opcTable [11] = '{`OPC_LDA_IMM, `OPC_ADC_IMM, `OPC_SBC_IMM, `OPC_AND_IMM,
                                `OPC_ORA_IMM, `OPC_EOR_IMM, `OPC_STA_ZP, `OPC_CLC,
                                `OPC_SEC, `OPC_CLD, `OPC_SED};
  integer     seed = 50;

  // reference model state
  logic [7:0]  mA;
  logic        mN;
  logic        mV;
  logic        mD;
  logic        mZ;
  logic        mC;
  logic [15:0] mPc;
  logic [15:0] curPc;
  logic        writePending;
  logic [15:0] wrAddr;
  logic [7:0]  wrData;
  // bus cycle the model expects next
  // 0 opcode fetch, 1 operand or dummy read, 2 store write
  int          cyclePhase;
  int          instrCount;
  int          decCount;
  int          cycleCount;
  logic        finished;
  logic        newCycle;
  logic [15:0] lastAddr;

  cpuTop dut (
    .fastClk (fastClk),
    .rstN    (rstN),
    .rdy     (rdy),
    .dataIn  (dataIn),
    .addr    (addr),
    .rw      (rw),
    .dataOut (dataOut),
    .sync    (sync),
    .status  (status)
  );

  always #4 fastClk = ~fastClk;

  // read data comes straight from the array
  // zero page writes land on the clock edge
  assign dataIn = rw ? mem[addr] : 8'h00;

  always @(posedge fastClk) begin
    if (rstN && !rw) begin
      mem[addr] <= dataOut;
    end
  end

  // run limit
  always @(posedge fastClk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount == MAX_CYCLES) begin
      $display("Timeout at %0t: the core stopped fetching instructions", $time);
      $display("TB FAILED");
      $fatal(1, "run limit reached");
    end
  end

  task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual,
                            input string what);
    if (actual !== expected) begin
      $display("Error at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int instrLength(input logic [7:0] opc);
    case (opc)
      `OPC_LDA_IMM, `OPC_ADC_IMM, `OPC_SBC_IMM, `OPC_AND_IMM,
      `OPC_ORA_IMM, `OPC_EOR_IMM, `OPC_STA_ZP: return 2;
      default: return 1;
    endcase
  endfunction

  // N V 1 B D I Z C
  function automatic logic [7:0] expectedStatus();
    return {mN, mV, 1'b1, 1'b0, mD, 1'b0, mZ, mC};
  endfunction

  // random opcodes with BCD operands while D is set
  task automatic buildProgram();
    logic [15:0] pc;
    logic [7:0]  opc;
    logic [7:0]  opnd;
    logic        dFlag;
    int          pick;
    int          i;
    pc    = `CPU_RESET_PC;
    dFlag = 1'b0;
    for (i = 0; i < NUM_INSTR; i++) begin
      pick = $unsigned($random(seed)) % 12;
      // one draw in twelve is any byte at all
      opc  = (pick < 11) ? opcTable[pick] : 8'($random(seed));
      opnd = 8'($random(seed));
      if (dFlag) begin
        opnd = {4'(opnd[7:4] % 10), 4'(opnd[3:0] % 10)};
      end
      mem[pc] = opc;
      if (instrLength(opc) == 2) begin
        mem[pc + 16'd1] = opnd;
      end
      if (opc == `OPC_SED) begin
        dFlag = 1'b1;
      end else if (opc == `OPC_CLD) begin
        dFlag = 1'b0;
      end
      pc = pc + 16'(instrLength(opc));
    end
  endtask

  task automatic setNZ();
    mN = mA[7];
    mZ = (mA == 8'h00);
  endtask

  task automatic addModel(input logic [7:0] b);
    int         binSum;
    int         lo;
    int         hi;
    logic [7:0] bin;
    binSum = int'(mA) + int'(b) + (mC ? 1 : 0);
    bin    = binSum[7:0];
    // overflow when both inputs share a sign the result lacks
    mV     = (((mA ^ bin) & (b ^ bin) & 8'h80) != 8'h00);
    if (mD) begin
      lo = int'(mA[3:0]) + int'(b[3:0]) + (mC ? 1 : 0);
      if (lo > 9) lo = lo + 6;
      hi = int'(mA[7:4]) + int'(b[7:4]) + ((lo > 15) ? 1 : 0);
      if (hi > 9) hi = hi + 6;
      mC = (hi > 15);
      mA = {hi[3:0], lo[3:0]};
    end else begin
      mC = (binSum > 255);
      mA = bin;
    end
    setNZ();
  endtask

  task automatic subModel(input logic [7:0] b);
    int         diff;
    int         lo;
    int         hi;
    logic       loBorrow;
    logic       hiBorrow;
    logic [7:0] bin;
    diff = int'(mA) - int'(b) - (mC ? 0 : 1);
    bin  = diff[7:0];
    mV   = (((mA ^ b) & (mA ^ bin) & 8'h80) != 8'h00);
    if (mD) begin
      lo       = int'(mA[3:0]) - int'(b[3:0]) - (mC ? 0 : 1);
      loBorrow = (lo < 0);
      hi       = int'(mA[7:4]) - int'(b[7:4]) - (loBorrow ? 1 : 0);
      hiBorrow = (hi < 0);
      // a digit that borrowed loses 6
      if (loBorrow) lo = lo - 6;
      if (hiBorrow) hi = hi - 6;
      mC = !hiBorrow;
      mA = {hi[3:0], lo[3:0]};
    end else begin
      mC = (diff >= 0);
      mA = bin;
    end
    setNZ();
  endtask

  task automatic applyInstr(input logic [7:0] opc, input logic [7:0] opnd);
    case (opc)
      `OPC_LDA_IMM: begin
        mA = opnd;
        setNZ();
      end
      `OPC_AND_IMM: begin
        mA = mA & opnd;
        setNZ();
      end
      `OPC_ORA_IMM: begin
        mA = mA | opnd;
        setNZ();
      end
      `OPC_EOR_IMM: begin
        mA = mA ^ opnd;
        setNZ();
      end
      `OPC_ADC_IMM, `OPC_SBC_IMM: begin
        if (mD) decCount = decCount + 1;
        if (opc == `OPC_ADC_IMM) addModel(opnd);
        else subModel(opnd);
      end
      `OPC_STA_ZP: begin
        writePending = 1'b1;
        wrAddr       = {8'h00, opnd};
        wrData       = mA;
      end
      `OPC_CLC: mC = 1'b0;
      `OPC_SEC: mC = 1'b1;
      `OPC_CLD: mD = 1'b0;
      `OPC_SED: mD = 1'b1;
      default: ;
    endcase
    mPc = mPc + 16'(instrLength(opc));
  endtask

  // each bus cycle is seen once even when rdy stretches it
  task automatic observeCycle();
    case (cyclePhase)
      0: begin
        checkValue(1, sync, "sync during opcode fetch");
        checkValue(1, rw, "rw during opcode fetch");
        checkValue(mPc, addr, "opcode fetch address");
        checkValue(expectedStatus(), status, "status after previous instruction");
        if (instrCount == NUM_INSTR) begin
          finished = 1'b1;
        end else begin
          curPc = mPc;
          applyInstr(mem[mPc], mem[mPc + 16'd1]);
          instrCount = instrCount + 1;
          cyclePhase = 1;
        end
      end
      1: begin
        // operand byte or dummy read
        checkValue(0, sync, "sync during second cycle");
        checkValue(1, rw, "rw during second cycle");
        checkValue(curPc + 16'd1, addr, "second cycle read address");
        cyclePhase = writePending ? 2 : 0;
      end
      default: begin
        checkValue(0, sync, "sync during store write");
        checkValue(0, rw, "rw during store write");
        checkValue(wrAddr, addr, "store address");
        checkValue(wrData, dataOut, "store data");
        writePending = 1'b0;
        cyclePhase   = 0;
      end
    endcase
  endtask

  initial begin
    int a;
    rstN         = 1'b0;
    rdy          = 1'b1;
    cycleCount   = 0;
    {mA, mN, mV, mD, mZ, mC} = '0;
    mPc          = `CPU_RESET_PC;
    curPc        = `CPU_RESET_PC;
    writePending = 1'b0;
    wrAddr       = '0;
    wrData       = '0;
    cyclePhase   = 0;
    instrCount   = 0;
    decCount     = 0;
    finished     = 1'b0;
    for (a = 0; a < 65536; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h3C;
    end
    buildProgram();

    repeat (4) @(posedge fastClk);
    @(negedge fastClk);
    rstN = 1'b1;
    // reset values on the pins in the first fetch
    checkValue(`CPU_RESET_PC, addr, "first fetch address after reset");
    checkValue(8'h20, status, "status after reset");

    newCycle = 1'b1;
    lastAddr = addr;
    while (!finished) begin
      if (newCycle) begin
        observeCycle();
      end else begin
        checkValue(lastAddr, addr, "address held during stalled read");
      end
      lastAddr = addr;
      // rdy low on about 3 cycles in 10
      rdy      = ($unsigned($random(seed)) % 10) >= 3;
      newCycle = rdy || !rw;
      @(negedge fastClk);
    end

    checkValue(1, decCount > 0, "no decimal add or subtract ran");
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== rtl/cpuTop.sv ====
/* reduced 6502 core top: predecode input side, timing/ALU/status core,
   registered bus output side */
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpuTop
  import cpuPkg::*;
(
  input  logic                   fastClk,
  input  logic                   rstN,
  input  logic                   rdy,
  input  logic [`CPU_DATA_W-1:0] dataIn,
  output logic [`CPU_ADDR_W-1:0] addr,
  output logic                   rw,
  output logic [`CPU_DATA_W-1:0] dataOut,
  output logic                   sync,
  output logic [7:0]             status
);

  tState_e                state;
  decodedOp_t             opRec;
  logic [`CPU_DATA_W-1:0] operand;
  logic [`CPU_DATA_W-1:0] accumVal;
  logic                   execute;
  busReq_t                nextReq;
  aluResult_t             aluResult;
  statusFlags_t           flags;

  // input side
  predecoder uPredecoder (
    .fastClk (fastClk),
    .rstN    (rstN),
    .rdy     (rdy),
    .dataIn  (dataIn),
    .state   (state),
    .opRec   (opRec),
    .operand (operand)
  );

  // processing
  timingControl uTimingControl (
    .fastClk  (fastClk),
    .rstN     (rstN),
    .rdy      (rdy),
    .opRec    (opRec),
    .operand  (operand),
    .accumVal (accumVal),
    .state    (state),
    .execute  (execute),
    .nextReq  (nextReq)
  );

  aluDecimal uAlu (
    .a       (accumVal),
    .b       (operand),
    .op      (opRec.op),
    .carryIn (flags.c),
    .decimal (flags.d),
    .result  (aluResult)
  );

  statusRegister uStatus (
    .fastClk  (fastClk),
    .rstN     (rstN),
    .execute  (execute),
    .op       (opRec.op),
    .flagOp   (opRec.flagOp),
    .result   (aluResult),
    .accumVal (accumVal),
    .flags    (flags)
  );

  // output side
  busOutput uBusOutput (
    .fastClk (fastClk),
    .rstN    (rstN),
    .rdy     (rdy),
    .nextReq (nextReq),
    .addr    (addr),
    .rw      (rw),
    .dataOut (dataOut),
    .sync    (sync)
  );

  // 6502 order N V 1 B D I Z C, B and I read as zero
  assign status = {flags.n, flags.v, 1'b1, 1'b0, flags.d, 1'b0, flags.z, flags.c};

endmodule

// ==== rtl/busOutput.sv ====
/* registered address, rw, data-out and sync drivers */
`timescale 1ns/1ps
`include "cpu_params.svh"

module busOutput
  import cpuPkg::*;
(
  input  logic                   fastClk,
  input  logic                   rstN,
  input  logic                   rdy,
  input  busReq_t                nextReq,
  output logic [`CPU_ADDR_W-1:0] addr,
  output logic                   rw,
  output logic [`CPU_DATA_W-1:0] dataOut,
  output logic                   sync
);

  logic hold;

  // rdy low only freezes a read, a write on the pins always goes through
  assign hold = !rdy && rw;

  // loads every cycle unless the read is stalled
  always_ff @(posedge fastClk) begin
    if (!rstN) begin
      // first cycle out of reset is the opcode fetch
      addr    <= `CPU_RESET_PC;
      rw      <= 1'b1;
      dataOut <= '0;
      sync    <= 1'b1;
    end else if (!hold) begin
      addr    <= nextReq.addr;
      rw      <= nextReq.rw;
      dataOut <= nextReq.dataOut;
      sync    <= nextReq.sync;
    end
  end

endmodule

// ==== rtl/statusRegister.sv ====
/* accumulator and N V D Z C flag register */
`timescale 1ns/1ps
`include "cpu_params.svh"

module statusRegister
  import cpuPkg::*;
(
  input  logic                   fastClk,
  input  logic                   rstN,
  input  logic                   execute,
  input  aluOp_e                 op,
  input  flagOp_e                flagOp,
  input  aluResult_t             result,
  output logic [`CPU_DATA_W-1:0] accumVal,
  output statusFlags_t           flags
);

  always_ff @(posedge fastClk) begin
    if (!rstN) begin
      accumVal <= '0;
      flags    <= '0;
    end else if (execute) begin
      case (op)
        // load and logic ops touch N and Z only
        opLoad, opAnd, opOr, opXor: begin
          accumVal <= result.value;
          flags.n  <= result.n;
          flags.z  <= result.z;
        end
        // arithmetic also updates V and C
        opAdd, opSub: begin
          accumVal <= result.value;
          flags.n  <= result.n;
          flags.v  <= result.v;
          flags.z  <= result.z;
          flags.c  <= result.c;
        end
        opFlag: begin
          case (flagOp)
            fClrC: flags.c <= 1'b0;
            fSetC: flags.c <= 1'b1;
            fClrD: flags.d <= 1'b0;
            fSetD: flags.d <= 1'b1;
            default: ;
          endcase
        end
        // nop, nothing changes
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/aluDecimal.sv ====
/* ALU: binary and BCD add and subtract, load and logic operations,
   with N V Z C results */
`timescale 1ns/1ps
`include "cpu_params.svh"

module aluDecimal
  import cpuPkg::*;
(
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  input  aluOp_e                 op,
  input  logic                   carryIn,
  input  logic                   decimal,
  output aluResult_t             result
);

  logic [`CPU_DATA_W:0]   binSum;
  logic [`CPU_DATA_W:0]   binDiff;
  logic [4:0]             loAdd;
  logic [4:0]             hiAdd;
  logic [4:0]             loSub;
  logic [4:0]             hiSub;
  logic                   loBorrow;
  logic                   hiBorrow;
  logic [`CPU_DATA_W-1:0] resValue;
  logic                   vOut;
  logic                   cOut;

  // binary paths, top bit is carry out
  assign binSum  = {1'b0, a} + {1'b0, b} + {{`CPU_DATA_W{1'b0}}, carryIn};
  // subtract as a plus not b, top bit set means no borrow
  assign binDiff = {1'b0, a} + {1'b0, ~b} + {{`CPU_DATA_W{1'b0}}, carryIn};

  // decimal add, one digit at a time
  always_comb begin
    loAdd = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, carryIn};
    if (loAdd > 5'd9) begin
      loAdd = loAdd + 5'd6;
    end
    // bit 4 of the adjusted low digit carries into the high digit
    hiAdd = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'd0, loAdd[4]};
    if (hiAdd > 5'd9) begin
      hiAdd = hiAdd + 5'd6;
    end
  end

  // decimal subtract, borrow taken before the digit is corrected
  always_comb begin
    loSub    = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, ~carryIn};
    loBorrow = loSub[4];
    hiSub    = {1'b0, a[7:4]} - {1'b0, b[7:4]} - {4'd0, loBorrow};
    hiBorrow = hiSub[4];
    if (loBorrow) begin
      loSub = loSub - 5'd6;
    end
    if (hiBorrow) begin
      hiSub = hiSub - 5'd6;
    end
  end

  // operation select
  always_comb begin
    resValue = a;
    vOut     = 1'b0;
    cOut     = carryIn;
    case (op)
      opLoad: resValue = b;
      opAnd:  resValue = a & b;
      opOr:   resValue = a | b;
      opXor:  resValue = a ^ b;
      opAdd: begin
        // overflow from the binary sum in both modes
        vOut = (a[7] == b[7]) && (binSum[7] != a[7]);
        if (decimal) begin
          resValue = {hiAdd[3:0], loAdd[3:0]};
          cOut     = hiAdd[4];
        end else begin
          resValue = binSum[`CPU_DATA_W-1:0];
          cOut     = binSum[`CPU_DATA_W];
        end
      end
      opSub: begin
        vOut = (a[7] != b[7]) && (binDiff[7] != a[7]);
        if (decimal) begin
          resValue = {hiSub[3:0], loSub[3:0]};
          cOut     = ~hiBorrow;
        end else begin
          resValue = binDiff[`CPU_DATA_W-1:0];
          cOut     = binDiff[`CPU_DATA_W];
        end
      end
      // store, flag and nop leave a untouched
      default: ;
    endcase
  end

  // N and Z from whatever value is finally produced
  assign result = '{value: resValue, n: resValue[`CPU_DATA_W-1], v: vOut,
                    z: (resValue == '0), c: cOut};

endmodule

// ==== rtl/timingControl.sv ====
/* T-state sequencer, program counter and next bus request */
`timescale 1ns/1ps
`include "cpu_params.svh"

module timingControl
  import cpuPkg::*;
(
  input  logic                   fastClk,
  input  logic                   rstN,
  input  logic                   rdy,
  input  decodedOp_t             opRec,
  input  logic [`CPU_DATA_W-1:0] operand,
  input  logic [`CPU_DATA_W-1:0] accumVal,
  output tState_e                state,
  output logic                   execute,
  output busReq_t                nextReq
);

  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_ADDR_W-1:0] pcNext;
  logic [`CPU_ADDR_W-1:0] zpAddr;
  tState_e                stateNext;
  logic                   advance;

  // a read cycle stretches while rdy is low
  // the write cycle always completes
  assign advance = rdy || (state == tWrite);

  // start of the following instruction
  assign pcNext = opRec.hasOperand ? pc + `CPU_ADDR_W'(2) : pc + `CPU_ADDR_W'(1);

  // page zero, low byte from the operand
  assign zpAddr = {{(`CPU_ADDR_W - `CPU_DATA_W){1'b0}}, operand};

  // result lands in the accumulator and flags at the end of T1
  assign execute = rdy && (state == tOperand) && (opRec.op != opStore);

  // request for the cycle after this one
  always_comb begin
    stateNext       = state;
    nextReq.addr    = pc;
    nextReq.rw      = 1'b1;
    nextReq.dataOut = accumVal;
    nextReq.sync    = 1'b0;
    case (state)
      tFetch: begin
        // second byte or dummy read
        stateNext    = tOperand;
        nextReq.addr = pc + `CPU_ADDR_W'(1);
      end
      tOperand: begin
        if (opRec.op == opStore) begin
          stateNext    = tWrite;
          nextReq.addr = zpAddr;
          nextReq.rw   = 1'b0;
        end else begin
          stateNext    = tFetch;
          nextReq.addr = pcNext;
          nextReq.sync = 1'b1;
        end
      end
      tWrite: begin
        // pc already points past the store
        stateNext    = tFetch;
        nextReq.addr = pc;
        nextReq.sync = 1'b1;
      end
      default: begin
        stateNext = tFetch;
      end
    endcase
  end

  always_ff @(posedge fastClk) begin
    if (!rstN) begin
      state <= tFetch;
      pc    <= `CPU_RESET_PC;
    end else if (advance) begin
      state <= stateNext;
      // pc moves once per instruction, at the end of T1
      if (state == tOperand) begin
        pc <= pcNext;
      end
    end
  end

endmodule

// ==== rtl/predecoder.sv ====
/* opcode predecode and operand capture from the input data bus */
`timescale 1ns/1ps
`include "cpu_params.svh"

module predecoder
  import cpuPkg::*;
(
  input  logic                   fastClk,
  input  logic                   rstN,
  input  logic                   rdy,
  input  logic [`CPU_DATA_W-1:0] dataIn,
  input  tState_e                state,
  output decodedOp_t             opRec,
  output logic [`CPU_DATA_W-1:0] operand
);

  decodedOp_t             decoded;
  logic [`CPU_DATA_W-1:0] operandQ;

  // opcode byte to operation record
  always_comb begin
    decoded = '{op: opNop, flagOp: fNone, hasOperand: 1'b0};
    case (dataIn)
      `OPC_LDA_IMM: decoded = '{op: opLoad, flagOp: fNone, hasOperand: 1'b1};
      `OPC_ADC_IMM: decoded = '{op: opAdd, flagOp: fNone, hasOperand: 1'b1};
      `OPC_SBC_IMM: decoded = '{op: opSub, flagOp: fNone, hasOperand: 1'b1};
      `OPC_AND_IMM: decoded = '{op: opAnd, flagOp: fNone, hasOperand: 1'b1};
      `OPC_ORA_IMM: decoded = '{op: opOr, flagOp: fNone, hasOperand: 1'b1};
      `OPC_EOR_IMM: decoded = '{op: opXor, flagOp: fNone, hasOperand: 1'b1};
      `OPC_STA_ZP:  decoded = '{op: opStore, flagOp: fNone, hasOperand: 1'b1};
      `OPC_CLC:     decoded = '{op: opFlag, flagOp: fClrC, hasOperand: 1'b0};
      `OPC_SEC:     decoded = '{op: opFlag, flagOp: fSetC, hasOperand: 1'b0};
      `OPC_CLD:     decoded = '{op: opFlag, flagOp: fClrD, hasOperand: 1'b0};
      `OPC_SED:     decoded = '{op: opFlag, flagOp: fSetD, hasOperand: 1'b0};
      // anything else runs as a one byte nop
      default: ;
    endcase
  end

  // opcode taken at the end of T0, held through the rest of the instruction
  always_ff @(posedge fastClk) begin
    if (!rstN) begin
      opRec <= '{op: opNop, flagOp: fNone, hasOperand: 1'b0};
    end else if (rdy && state == tFetch) begin
      opRec <= decoded;
    end
  end

  // operand byte taken at the end of T1
  always_ff @(posedge fastClk) begin
    if (rdy && state == tOperand) begin
      operandQ <= dataIn;
    end
  end

  // during T1 the byte comes straight off the bus
  // so the ALU and the zero page address see it in the same cycle
  assign operand = (state == tOperand) ? dataIn : operandQ;

endmodule

// ==== rtl/cpuPkg.sv ====
/* shared types: T-states, ALU and flag operations, decoded opcode record,
   bus request, ALU result and status flags */
`include "cpu_params.svh"

package cpuPkg;

  // type of the bus cycle currently on the pins
  typedef enum logic [1:0] {
    tFetch,
    tOperand,
    tWrite
  } tState_e;

  // what the ALU and accumulator do with the operand
  typedef enum logic [3:0] {
    opLoad,
    opAdd,
    opSub,
    opAnd,
    opOr,
    opXor,
    opStore,
    opFlag,
    opNop
  } aluOp_e;

  // set or clear of a single status bit
  typedef enum logic [2:0] {
    fNone,
    fClrC,
    fSetC,
    fClrD,
    fSetD
  } flagOp_e;

  typedef struct packed {
    aluOp_e  op;
    flagOp_e flagOp;
    // second byte follows the opcode
    logic    hasOperand;
  } decodedOp_t;

  // one bus cycle as requested by the sequencer
  typedef struct packed {
    logic [`CPU_ADDR_W-1:0] addr;
    logic                   rw;
    logic [`CPU_DATA_W-1:0] dataOut;
    logic                   sync;
  } busReq_t;

  typedef struct packed {
    logic [`CPU_DATA_W-1:0] value;
    logic                   n;
    logic                   v;
    logic                   z;
    logic                   c;
  } aluResult_t;

  // I and B are not kept
  typedef struct packed {
    logic n;
    logic v;
    logic d;
    logic z;
    logic c;
  } statusFlags_t;

endpackage

// ==== include/cpu_params.svh ====
/* reset address, bus widths and opcode byte values of the reduced core */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// first opcode fetch after reset, no vector fetch
`define CPU_RESET_PC 16'h0200

// external bus widths
`define CPU_ADDR_W 16
`define CPU_DATA_W 8

// immediate mode group, two bytes each
`define OPC_LDA_IMM 8'hA9
`define OPC_ADC_IMM 8'h69
`define OPC_SBC_IMM 8'hE9
`define OPC_AND_IMM 8'h29
`define OPC_ORA_IMM 8'h09
`define OPC_EOR_IMM 8'h49

// zero page store, two bytes
`define OPC_STA_ZP  8'h85

// implied flag opcodes, one byte each
`define OPC_CLC     8'h18
`define OPC_SEC     8'h38
`define OPC_CLD     8'hD8
`define OPC_SED     8'hF8

`endif
